// ==== build.f ====
source/tlbmiss_pkg.sv
source/miss_buffer.sv
source/replay_sequencer.sv
source/tlbmiss_replay.sv
tb/tlbmiss_replay_assert.sv
tb/tlbmiss_replay_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tlbmiss_replay_tb \
  -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
exit 1

// ==== source/miss_buffer.sv ====
`timescale 1ns/1ps

module miss_buffer (
  input  logic                          clk,
  input  logic                          rst,
  input  tlbmiss_pkg::lane_t            lane0_i,
  input  tlbmiss_pkg::lane_t            lane1_i,
  input  logic [tlbmiss_pkg::LANES-1:0] miss_i,
  input  logic                          except_i,
  input  tlbmiss_pkg::thread_t          except_thread_i,
  input  logic                          pop_i,
  output tlbmiss_pkg::lane_t            head_lane0_o,
  output tlbmiss_pkg::lane_t            head_lane1_o,
  output logic                          empty_o
);

  tlbmiss_pkg::mem_op_t slot_op  [tlbmiss_pkg::SLOTS][tlbmiss_pkg::LANES];
  // thread copy kept next to the flags for the exception compare
  tlbmiss_pkg::thread_t slot_thr [tlbmiss_pkg::SLOTS][tlbmiss_pkg::LANES];

  // per-lane valid (missed) and dead flags
  logic [tlbmiss_pkg::LANES-1:0] slot_miss [tlbmiss_pkg::SLOTS];
  logic [tlbmiss_pkg::LANES-1:0] slot_dead [tlbmiss_pkg::SLOTS];

  tlbmiss_pkg::slot_ptr_t head_ptr;
  tlbmiss_pkg::slot_ptr_t tail_ptr;
  tlbmiss_pkg::slot_cnt_t count;

  tlbmiss_pkg::lane_t lane_in [tlbmiss_pkg::LANES];
  tlbmiss_pkg::lane_t head    [tlbmiss_pkg::LANES];
  logic               capture;

  assign lane_in[0]   = lane0_i;
  assign lane_in[1]   = lane1_i;
  assign capture      = |miss_i;
  assign empty_o      = (count == '0);
  assign head_lane0_o = head[0];
  assign head_lane1_o = head[1];

  always_ff @(posedge clk) begin
    if (capture) begin
      for (int l = 0; l < tlbmiss_pkg::LANES; l++) begin
        slot_op[tail_ptr][l]  <= lane_in[l].op;
        slot_thr[tail_ptr][l] <= lane_in[l].op.thread;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
      for (int s = 0; s < tlbmiss_pkg::SLOTS; s++) begin
        slot_miss[s] <= '0;
        slot_dead[s] <= '0;
      end
    end else begin
      if (except_i) begin
        for (int s = 0; s < tlbmiss_pkg::SLOTS; s++) begin
          for (int l = 0; l < tlbmiss_pkg::LANES; l++) begin
            if (slot_thr[s][l] == except_thread_i) begin
              slot_dead[s][l] <= 1'b1;
            end
          end
        end
      end

      if (pop_i) begin
        slot_miss[head_ptr] <= '0;
        slot_dead[head_ptr] <= '0;
        head_ptr            <= head_ptr + 1'b1;
      end

      // a capture hit by the same-cycle exception goes in already dead
      if (capture) begin
        slot_miss[tail_ptr] <= miss_i;
        for (int l = 0; l < tlbmiss_pkg::LANES; l++) begin
          slot_dead[tail_ptr][l] <= except_i && (lane_in[l].op.thread == except_thread_i);
        end
        tail_ptr <= tail_ptr + 1'b1;
      end

      case ({capture, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head view, already masked by an exception in this cycle
  for (genvar l = 0; l < tlbmiss_pkg::LANES; l++) begin : g_head
    logic kill_now;

    assign kill_now   = except_i && (slot_thr[head_ptr][l] == except_thread_i);
    assign head[l].en = slot_miss[head_ptr][l] && !slot_dead[head_ptr][l] && !kill_now;
    assign head[l].op = slot_op[head_ptr][l];
  end

endmodule

// ==== source/replay_sequencer.sv ====
`timescale 1ns/1ps

module replay_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  tlbmiss_pkg::lane_t  head_lane0_i,
  input  tlbmiss_pkg::lane_t  head_lane1_i,
  input  logic                empty_i,
  output logic                pop_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output tlbmiss_pkg::page_t  wb_adr_o,
  input  logic                wb_ack_i,
  output tlbmiss_pkg::lane_t  lane0_o,
  output tlbmiss_pkg::lane_t  lane1_o
);

  tlbmiss_pkg::replay_state_t state;
  logic                       req_q;
  logic                       ack_hit;
  tlbmiss_pkg::vaddr_t        req_vaddr;

  // classic cycle, cyc and stb move together
  assign wb_cyc_o = req_q;
  assign wb_stb_o = req_q;
  assign ack_hit  = req_q && wb_ack_i;

  // head payload is stable until pop, so the address holds through the cycle
  assign req_vaddr = (state == tlbmiss_pkg::RS_REQ1) ? head_lane1_i.op.addr
                                                     : head_lane0_i.op.addr;
  assign wb_adr_o  = req_vaddr[tlbmiss_pkg::VADDR_W-1:tlbmiss_pkg::PAGE_SHIFT];

  assign pop_o = (state == tlbmiss_pkg::RS_EMIT);

  always_comb begin
    lane0_o = head_lane0_i;
    lane1_o = head_lane1_i;
    if (state != tlbmiss_pkg::RS_EMIT) begin
      lane0_o.en = 1'b0;
      lane1_o.en = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tlbmiss_pkg::RS_IDLE;
      req_q <= 1'b0;
    end else begin
      case (state)
        tlbmiss_pkg::RS_IDLE: begin
          if (!empty_i) begin
            if (head_lane0_i.en) begin
              state <= tlbmiss_pkg::RS_REQ0;
              req_q <= 1'b1;
            end else if (head_lane1_i.en) begin
              state <= tlbmiss_pkg::RS_REQ1;
              req_q <= 1'b1;
            end else begin
              state <= tlbmiss_pkg::RS_EMIT;
            end
          end
        end

        tlbmiss_pkg::RS_REQ0: begin
          // stb drops here, lane 1 raises it again a cycle later
          if (ack_hit) begin
            req_q <= 1'b0;
            if (head_lane1_i.en) begin
              state <= tlbmiss_pkg::RS_REQ1;
            end else begin
              state <= tlbmiss_pkg::RS_EMIT;
            end
          end
        end

        tlbmiss_pkg::RS_REQ1: begin
          if (ack_hit) begin
            req_q <= 1'b0;
            state <= tlbmiss_pkg::RS_EMIT;
          end else if (!req_q) begin
            // gap cycle after lane 0, lane 1 may have died meanwhile
            if (head_lane1_i.en) begin
              req_q <= 1'b1;
            end else begin
              state <= tlbmiss_pkg::RS_EMIT;
            end
          end
        end

        tlbmiss_pkg::RS_EMIT: begin
          state <= tlbmiss_pkg::RS_IDLE;
        end

        default: begin
          state <= tlbmiss_pkg::RS_IDLE;
          req_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== source/tlbmiss_pkg.sv ====
package tlbmiss_pkg;

  localparam int LANES      = 2;
  localparam int SLOTS      = 4;
  localparam int PAGE_SHIFT = 14;
  localparam int VADDR_W    = 44;
  localparam int PAGE_W     = VADDR_W - PAGE_SHIFT;

  typedef logic [VADDR_W-1:0] vaddr_t;
  // page number, address bits above the page offset
  typedef logic [PAGE_W-1:0]  page_t;
  typedef logic               thread_t;
  typedef logic [4:0]         size_t;
  typedef logic [3:0]         attr_t;
  typedef logic [8:0]         lsq_t;

  typedef logic [$clog2(SLOTS)-1:0] slot_ptr_t;
  // one extra bit so a full buffer is distinct from an empty one
  typedef logic [$clog2(SLOTS):0]   slot_cnt_t;

  typedef struct packed {
    thread_t thread;
    vaddr_t  addr;
    size_t   size;
    attr_t   attr;
    lsq_t    lsq;
  } mem_op_t;

  typedef struct packed {
    logic    en;
    mem_op_t op;
  } lane_t;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_REQ0,
    RS_REQ1,
    RS_EMIT
  } replay_state_t;

endpackage

// ==== source/tlbmiss_replay.sv ====
`timescale 1ns/1ps

module tlbmiss_replay (
  input  logic                          clk,
  input  logic                          rst,
  input  tlbmiss_pkg::lane_t            lane0_i,
  input  tlbmiss_pkg::lane_t            lane1_i,
  input  logic [tlbmiss_pkg::LANES-1:0] miss_i,
  input  logic                          except_i,
  input  tlbmiss_pkg::thread_t          except_thread_i,
  output logic                          skip_o,
  output tlbmiss_pkg::lane_t            lane0_o,
  output tlbmiss_pkg::lane_t            lane1_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output tlbmiss_pkg::page_t            wb_adr_o,
  input  logic                          wb_ack_i
);

  tlbmiss_pkg::lane_t head_lane0;
  tlbmiss_pkg::lane_t head_lane1;
  logic               buf_empty;
  logic               buf_busy;
  logic               pop;

  // upstream skips while anything is parked
  assign buf_busy = ~buf_empty;
  assign skip_o   = buf_busy;

  miss_buffer u_buffer (
    .clk             (clk),
    .rst             (rst),
    .lane0_i         (lane0_i),
    .lane1_i         (lane1_i),
    .miss_i          (miss_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .pop_i           (pop),
    .head_lane0_o    (head_lane0),
    .head_lane1_o    (head_lane1),
    .empty_o         (buf_empty)
  );

  replay_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .head_lane0_i (head_lane0),
    .head_lane1_i (head_lane1),
    .empty_i      (buf_empty),
    .pop_o        (pop),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_ack_i     (wb_ack_i),
    .lane0_o      (lane0_o),
    .lane1_o      (lane1_o)
  );

endmodule

// ==== tb/tlbmiss_replay_assert.sv ====
`timescale 1ns/1ps

module tlbmiss_replay_assert (
  input logic               clk,
  input logic               rst,
  input logic               wb_cyc_i,
  input logic               wb_stb_i,
  input logic               wb_ack_i,
  input tlbmiss_pkg::page_t wb_adr_i,
  input logic [1:0]         miss_i,
  input logic               pop_i,
  input logic               lane0_en_i,
  input logic               lane1_en_i
);

  logic [2:0] occ;

  // occupancy shadow of the buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else begin
      occ <= occ + ((miss_i != 2'b00) ? 3'd1 : 3'd0) - (pop_i ? 3'd1 : 3'd0);
    end
  end

  a_drop: assert property (@(posedge clk) disable iff (rst)
      wb_stb_i && wb_ack_i |=> !wb_cyc_i && !wb_stb_i)
    else $error("cyc or stb still high after ack");

  a_hold: assert property (@(posedge clk) disable iff (rst)
      wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
    else $error("request dropped or address moved before ack");

  a_full: assert property (@(posedge clk) disable iff (rst) occ == 3'd4 |-> miss_i == 2'b00)
    else $error("capture into a full buffer");

  a_idle: assert property (@(posedge clk) disable iff (rst)
      !pop_i |-> !lane0_en_i && !lane1_en_i)
    else $error("output enable outside emit");

endmodule

bind tlbmiss_replay tlbmiss_replay_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .wb_cyc_i   (wb_cyc_o),
  .wb_stb_i   (wb_stb_o),
  .wb_ack_i   (wb_ack_i),
  .wb_adr_i   (wb_adr_o),
  .miss_i     (miss_i),
  .pop_i      (pop),
  .lane0_en_i (lane0_o.en),
  .lane1_en_i (lane1_o.en)
);

// ==== tb/tlbmiss_replay_tb.sv ====
`timescale 1ns/1ps

module tlbmiss_replay_tb;

  typedef struct packed {
    logic [2:0] n;
    logic [7:0] miss;
    logic [7:0] thr;
    logic       exc;
    logic [1:0] eidx;
    logic       ethr;
    logic [3:0] delay;
  } row_t;

  localparam int NROWS = 5;

  logic                 clk;
  logic                 rst;
  tlbmiss_pkg::lane_t   lane0_i;
  tlbmiss_pkg::lane_t   lane1_i;
  logic [1:0]           miss_i;
  logic                 except_i;
  tlbmiss_pkg::thread_t except_thread_i;
  logic                 skip_o;
  tlbmiss_pkg::lane_t   lane0_o;
  tlbmiss_pkg::lane_t   lane1_o;
  logic                 wb_cyc_o;
  logic                 wb_stb_o;
  tlbmiss_pkg::page_t   wb_adr_o;
  logic                 wb_ack_i;

  integer               seed = 32'h902a7d8a;
  int                   cur_delay;
  int                   wait_cnt;
  int                   occ;
  row_t                 rows [NROWS];
  tlbmiss_pkg::page_t   exp_req [$];
  tlbmiss_pkg::lane_t   exp_emit [$];

  tlbmiss_replay dut (
    .clk             (clk),
    .rst             (rst),
    .lane0_i         (lane0_i),
    .lane1_i         (lane1_i),
    .miss_i          (miss_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .skip_o          (skip_o),
    .lane0_o         (lane0_o),
    .lane1_o         (lane1_o),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_adr_o        (wb_adr_o),
    .wb_ack_i        (wb_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_page(input string name, input tlbmiss_pkg::page_t exp,
                            input tlbmiss_pkg::page_t act);
    if (exp !== act) begin
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_lane(input string name, input tlbmiss_pkg::lane_t exp,
                            input tlbmiss_pkg::lane_t act);
    if (exp !== act) begin
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_stop($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  // ack after a random number of wait cycles, up to the row's delay
  initial begin
    wb_ack_i = 1'b0;
    wait_cnt = 0;
    forever begin
      @(negedge clk);
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
      end else if (wb_stb_o) begin
        if (wait_cnt == 0) begin
          wb_ack_i = 1'b1;
          wait_cnt = $unsigned($random(seed)) % (cur_delay + 1);
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // sample just after the falling edge, once the new inputs have settled
  initial begin
    occ = 0;
    forever begin
      @(negedge clk);
      #1;
      if (!rst) begin
        check_bit("skip", occ > 0, skip_o);
        if (wb_stb_o && wb_ack_i) begin
          if (exp_req.size() == 0) fail_stop("unexpected Wishbone request");
          check_bit("request cyc", 1'b1, wb_cyc_o);
          check_page("request address", exp_req.pop_front(), wb_adr_o);
        end
        if (dut.pop) begin
          if (exp_emit.size() < 2) fail_stop("unexpected emit of a slot");
          check_bit("emit cyc", 1'b0, wb_cyc_o);
          check_lane("emit lane 0", exp_emit.pop_front(), lane0_o);
          check_lane("emit lane 1", exp_emit.pop_front(), lane1_o);
          occ--;
        end else begin
          check_bit("idle lane 0 enable", 1'b0, lane0_o.en);
          check_bit("idle lane 1 enable", 1'b0, lane1_o.en);
        end
        if (miss_i != 2'b00) occ++;
      end
    end
  end

  task automatic apply_row(input int r);
    row_t               rw;
    tlbmiss_pkg::lane_t ln [2];
    logic               live;
    rw = rows[r];
    cur_delay = int'(rw.delay);
    for (int c = 0; c < int'(rw.n); c++) begin
      @(negedge clk);
      for (int l = 0; l < 2; l++) begin
        ln[l].op.thread = rw.thr[2*c+l];
        ln[l].op.addr   = {12'($random(seed)), 32'($random(seed))};
        ln[l].op.size   = 5'($random(seed));
        ln[l].op.attr   = 4'($random(seed));
        ln[l].op.lsq    = 9'($random(seed));
        ln[l].en        = rw.miss[2*c+l];
        // dead if an exception of its thread comes at or after its capture
        live = rw.miss[2*c+l] &&
               !(rw.exc && c <= int'(rw.eidx) && rw.thr[2*c+l] == rw.ethr);
        if (live) exp_req.push_back(ln[l].op.addr[43:tlbmiss_pkg::PAGE_SHIFT]);
        exp_emit.push_back({live, ln[l].op});
      end
      lane0_i         = ln[0];
      lane1_i         = ln[1];
      miss_i          = rw.miss[2*c+:2];
      except_i        = rw.exc && (int'(rw.eidx) == c);
      except_thread_i = rw.ethr;
    end
    @(negedge clk);
    miss_i   = 2'b00;
    except_i = 1'b0;
  endtask

  task automatic wait_drain(input int r);
    int n;
    n = 0;
    while (exp_req.size() != 0 || exp_emit.size() != 0 || skip_o) begin
      @(negedge clk);
      n++;
      if (n > 300) fail_stop($sformatf("timeout waiting for row %0d to drain", r));
    end
  endtask

  initial begin
    rst             = 1'b1;
    lane0_i         = '0;
    lane1_i         = '0;
    miss_i          = 2'b00;
    except_i        = 1'b0;
    except_thread_i = 1'b0;
    cur_delay       = 0;
    // n, miss, thread, exc, exc index, exc thread, delay
    rows[0] = '{3'd1, 8'b00_00_00_11, 8'b00_00_00_00, 1'b0, 2'd0, 1'b0, 4'd0};
    rows[1] = '{3'd1, 8'b00_00_00_10, 8'b00_00_00_01, 1'b0, 2'd0, 1'b0, 4'd1};
    rows[2] = '{3'd4, 8'b11_10_01_11, 8'b01_10_00_11, 1'b0, 2'd0, 1'b0, 4'd3};
    rows[3] = '{3'd4, 8'b11_11_11_11, 8'b01_00_10_11, 1'b1, 2'd3, 1'b0, 4'd2};
    rows[4] = '{3'd2, 8'b00_00_11_11, 8'b00_00_00_10, 1'b1, 2'd0, 1'b0, 4'd1};
    repeat (3) @(negedge clk);
    rst = 1'b0;
    #1;
    check_bit("reset skip", 1'b0, skip_o);
    check_bit("reset cyc", 1'b0, wb_cyc_o);
    check_bit("reset stb", 1'b0, wb_stb_o);
    check_bit("reset lane 0 enable", 1'b0, lane0_o.en);
    check_bit("reset lane 1 enable", 1'b0, lane1_o.en);
    for (int r = 0; r < NROWS; r++) begin
      apply_row(r);
      wait_drain(r);
      repeat (2) @(negedge clk);
    end
    if (exp_req.size() != 0 || exp_emit.size() != 0) begin
      fail_stop("expected requests or emits never appeared");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
